// File: flist.f
source/xbar_cfg_pkg.sv
source/xbar_types_pkg.sv
source/master_port.sv
source/bank_arbiter.sv
source/tcdm_xbar.sv
tests/tb_clock_gen.sv
tests/tcdm_xbar_props.sv
tests/tcdm_xbar_tb.sv

// File: Makefile
# Verilator flow for the TCDM crossbar

VERILATOR ?= verilator
FLIST     ?= flist.f
TB_TOP    ?= tcdm_xbar_tb
RTL_TOP   ?= tcdm_xbar
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= All tests passed!

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TB_TOP)

$(OBJ_DIR)/V$(TB_TOP): $(FLIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TB_TOP) \
		--Mdir $(OBJ_DIR) -o V$(TB_TOP)

sim: $(OBJ_DIR)/V$(TB_TOP)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: tests/tcdm_xbar_tb.sv
/* Crossbar testbench
   Table driven stimulus with a behavioral bank model and a reference memory */
`timescale 1ns/1ps

module tcdm_xbar_tb
    import xbar_cfg_pkg::*, xbar_types_pkg::*;
;
    localparam int unsigned NM = 4;
    localparam int unsigned NB = 4;

    // One stimulus row, one cycle
    typedef struct packed
    {
        logic [NM-1:0]      req;
        addr_t [NM-1:0]     addr;
        logic [NM-1:0]      wen;     // 1 load
        data_t [NM-1:0]     wdata;
        logic [4*NM-1:0]    be;      // 4 bits per master
        logic [NB-1:0]      en;      // Bank grant enables
        logic [NM-1:0]      win;     // Master visible at its bank
        logic [NM-1:0]      gnt;     // Expected gnt_o
    } row_t;

    logic clk;
    logic rst_n;

    logic [NM-1:0]          req;
    mst_req_t [NM-1:0]      mst_req;
    logic [NM-1:0]          gnt;
    logic [NM-1:0]          r_valid;
    data_t [NM-1:0]         r_rdata;
    logic [NB-1:0]          bank_req;
    bank_req_t [NB-1:0]     bank_payload;
    logic [NB-1:0][NM-1:0]  bank_id;
    logic [NB-1:0]          bank_gnt;
    logic [NB-1:0]          bank_r_valid;
    data_t [NB-1:0]         bank_r_rdata;
    logic [NB-1:0][NM-1:0]  bank_r_id;

    row_t   rows[$];
    data_t  ref_mem[int];              // Word address keyed
    data_t  bank_mem[NB][4096];
    integer seed = 32'h4661;
    logic   table_ready = 1'b0;

    tb_clock_gen #(.PERIOD_NS(4.0), .RST_CYCLES(10)) clock_gen_i (
        .clk_o   ( clk   ),
        .rst_n_o ( rst_n )
    );

    tcdm_xbar #(.N_MASTER(NM), .N_BANK(NB)) tcdm_xbar_i (
        .clk            ( clk          ),
        .rst_n_i        ( rst_n        ),
        .req_i          ( req          ),
        .mst_req_i      ( mst_req      ),
        .gnt_o          ( gnt          ),
        .r_valid_o      ( r_valid      ),
        .r_rdata_o      ( r_rdata      ),
        .bank_req_o     ( bank_req     ),
        .bank_payload_o ( bank_payload ),
        .bank_id_o      ( bank_id      ),
        .bank_gnt_i     ( bank_gnt     ),
        .bank_r_valid_i ( bank_r_valid ),
        .bank_r_rdata_i ( bank_r_rdata ),
        .bank_r_id_i    ( bank_r_id    )
    );

    //////////////////////////////
    // Reporting and compares
    //////////////////////////////
    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_bank_req(input int b, input bank_req_t got, input bank_req_t exp,
                                  input logic [NM-1:0] got_id, input logic [NM-1:0] exp_id);
        if (got !== exp)
            stop_on_error($sformatf("error bank_payload_o[%0d] got %h expected %h",
                                    b, got, exp));
        if (got_id !== exp_id)
            stop_on_error($sformatf("error bank_id_o[%0d] got %h expected %h",
                                    b, got_id, exp_id));
    endtask

    task automatic check_gnt(input string name, input logic [3:0] got, input logic [3:0] exp);
        if (got !== exp)
            stop_on_error($sformatf("error %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_rsp(input int m, input data_t got, input data_t exp);
        if (got !== exp)
            stop_on_error($sformatf("error r_rdata_o[%0d] got %h expected %h", m, got, exp));
    endtask

    // Interleaving, bank above the byte offset and local word above the bank
    function automatic int bank_of(input addr_t a);
        return int'(a[BYTE_OFFSET +: 2]);
    endfunction

    function automatic bank_addr_t local_of(input addr_t a);
        return a[BYTE_OFFSET + 2 +: BANK_ADDR_WIDTH];
    endfunction

    //////////////////////////////
    // Stimulus table
    //////////////////////////////
    task automatic add_row(input logic [3:0] rq, input addr_t a0, input addr_t a1,
                           input addr_t a2, input addr_t a3, input logic [3:0] wen,
                           input logic [15:0] be, input logic [3:0] en,
                           input logic [3:0] win, input logic [3:0] g);
        row_t r;
        row_t prev;
        r.req  = rq;
        r.addr = {a3, a2, a1, a0};
        r.wen  = wen;
        r.be   = be;
        r.en   = en;
        r.win  = win;
        r.gnt  = g;
        for (int m = 0; m < NM; m++)
            r.wdata[m] = $random(seed);
        if (rows.size() > 0)
        begin
            prev = rows[rows.size()-1];
            for (int m = 0; m < NM; m++)
                if (prev.req[m] && !prev.gnt[m])
                    r.wdata[m] = prev.wdata[m];    // Held request keeps its data
        end
        rows.push_back(r);
    endtask

    task automatic build_table();
        add_row(4'b0000, 0, 0, 0, 0, 4'h0, 16'hFFFF, 4'hF, 4'b0000, 4'b0000);
        // Decode, lone stores
        add_row(4'b0100, 0, 0, 32'h128, 0, 4'h0, 16'hFFFF, 4'hF, 4'b0100, 4'b0100);
        add_row(4'b0010, 0, 32'h34, 0, 0, 4'h0, 16'hFFFF, 4'hF, 4'b0010, 4'b0010);
        add_row(4'b0010, 0, 32'h34, 0, 0, 4'h0, 16'hFF3F, 4'hF, 4'b0010, 4'b0010); // Half word
        // Back-pressure on bank 3
        add_row(4'b1000, 0, 0, 0, 32'h4C, 4'h0, 16'hFFFF, 4'h7, 4'b1000, 4'b0000);
        add_row(4'b1000, 0, 0, 0, 32'h4C, 4'h0, 16'hFFFF, 4'h7, 4'b1000, 4'b0000);
        add_row(4'b1000, 0, 0, 0, 32'h4C, 4'h0, 16'hFFFF, 4'hF, 4'b1000, 4'b1000);
        // Round robin on bank 0
        add_row(4'b1111, 32'h100, 32'h200, 32'h300, 32'h400, 4'h0, 16'hFFFF, 4'hF,
                4'b0001, 4'b0001);
        add_row(4'b1111, 32'h100, 32'h200, 32'h300, 32'h400, 4'h0, 16'hFFFF, 4'hF,
                4'b0010, 4'b0010);
        add_row(4'b1111, 32'h100, 32'h200, 32'h300, 32'h400, 4'h0, 16'hFFFF, 4'hF,
                4'b0100, 4'b0100);
        add_row(4'b1111, 32'h100, 32'h200, 32'h300, 32'h400, 4'h0, 16'hFFFF, 4'hF,
                4'b1000, 4'b1000);
        add_row(4'b1111, 32'h100, 32'h200, 32'h300, 32'h400, 4'h0, 16'hFFFF, 4'hF,
                4'b0001, 4'b0001);
        // Parallel loads, four banks at once
        add_row(4'b1111, 32'h34, 32'h128, 32'h4C, 32'h400, 4'hF, 16'hFFFF, 4'hF,
                4'b1111, 4'b1111);
        add_row(4'b0000, 0, 0, 0, 0, 4'h0, 16'hFFFF, 4'hF, 4'b0000, 4'b0000);
        // Two banks answer two masters
        add_row(4'b1001, 32'h128, 0, 0, 32'h34, 4'hF, 16'hFFFF, 4'hF, 4'b1001, 4'b1001);
        add_row(4'b0000, 0, 0, 0, 0, 4'h0, 16'hFFFF, 4'hF, 4'b0000, 4'b0000);
        add_row(4'b0000, 0, 0, 0, 0, 4'h0, 16'hFFFF, 4'hF, 4'b0000, 4'b0000);
    endtask

    //////////////////////////////
    // Bank model
    //////////////////////////////
    initial
    begin
        for (int b = 0; b < NB; b++)
            for (int a = 0; a < 4096; a++)
                bank_mem[b][a] = 32'h5A00_0000 ^ (b << 12) ^ a ^ (a << 20);
        bank_r_valid = '0;
        bank_r_rdata = '0;
        bank_r_id    = '0;
    end

    always @(posedge clk)
    begin
        logic [NB-1:0]         xfer;
        logic [NB-1:0][NM-1:0] id;
        data_t [NB-1:0]        rd;
        bank_req_t             p;
        xfer = bank_req & bank_gnt;     // Sampled at the edge
        id   = bank_id;
        rd   = '0;
        for (int b = 0; b < NB; b++)
        begin
            p = bank_payload[b];
            if (xfer[b] && p.wen)
                rd[b] = bank_mem[b][p.addr];
            else if (xfer[b])
                for (int k = 0; k < BE_WIDTH; k++)
                    if (p.be[k])
                        bank_mem[b][p.addr][8*k +: 8] = p.wdata[8*k +: 8];
        end
        #1;
        bank_r_valid = xfer;            // Answer one cycle later
        bank_r_id    = id;
        bank_r_rdata = rd;
    end

    //////////////////////////////
    // Watchdog
    //////////////////////////////
    initial
    begin
        wait (table_ready);
        #((rows.size() + 20) * 4);
        $display("Watchdog expired, the run did not finish in time");
        $display("Test failures found");
        $fatal(1);
    end

    //////////////////////////////
    // Main sequence
    //////////////////////////////
    initial
    begin
        row_t           r;
        logic [NB-1:0]  exp_breq;
        logic [NM-1:0]  exp_rv;
        logic [NM-1:0]  exp_ld;
        data_t [NM-1:0] exp_rd;
        bank_req_t      exp_p;
        int             w;
        req      = '0;
        mst_req  = '0;
        bank_gnt = '0;
        exp_rv   = '0;
        exp_ld   = '0;
        exp_rd   = '0;
        build_table();
        table_ready = 1'b1;
        wait (rst_n);
        foreach (rows[i])
        begin
            r = rows[i];
            @(posedge clk);
            #1;
            req      = r.req;
            bank_gnt = r.en;
            for (int m = 0; m < NM; m++)
            begin
                mst_req[m].addr  = r.addr[m];
                mst_req[m].wen   = r.wen[m];
                mst_req[m].wdata = r.wdata[m];
                mst_req[m].be    = r.be[4*m +: 4];
            end
            #1;
            // Responses to last cycle's grants
            check_gnt("r_valid_o", r_valid, exp_rv);
            for (int m = 0; m < NM; m++)
                if (exp_ld[m])
                    check_rsp(m, r_rdata[m], exp_rd[m]);
            check_gnt("gnt_o", gnt, r.gnt);
            exp_breq = '0;
            for (int m = 0; m < NM; m++)
            begin
                if (r.win[m])
                begin
                    exp_breq[bank_of(r.addr[m])] = 1'b1;
                    exp_p.addr  = local_of(r.addr[m]);
                    exp_p.wen   = r.wen[m];
                    exp_p.wdata = r.wdata[m];
                    exp_p.be    = r.be[4*m +: 4];
                    check_bank_req(bank_of(r.addr[m]), bank_payload[bank_of(r.addr[m])],
                                   exp_p, bank_id[bank_of(r.addr[m])], NM'(1 << m));
                end
            end
            check_gnt("bank_req_o", bank_req, exp_breq);
            // Reference memory update for granted masters
            exp_rv = r.gnt;
            exp_ld = r.gnt & r.wen;
            for (int m = 0; m < NM; m++)
            begin
                w = int'(r.addr[m] >> BYTE_OFFSET);
                if (r.gnt[m] && r.wen[m])
                begin
                    if (!ref_mem.exists(w))
                        stop_on_error("Load from a word the test never stored");
                    exp_rd[m] = ref_mem[w];
                end
                else if (r.gnt[m])
                begin
                    if (!ref_mem.exists(w))
                        ref_mem[w] = '0;
                    for (int k = 0; k < BE_WIDTH; k++)
                        if (r.be[4*m + k])
                            ref_mem[w][8*k +: 8] = r.wdata[m][8*k +: 8];
                end
            end
        end
        $display("All tests passed!");
        $finish;
    end

endmodule

// File: tests/tcdm_xbar_props.sv
/* Crossbar port assertions
   One-hot bank IDs, single grant per master, no grant without request */
`timescale 1ns/1ps

module tcdm_xbar_props #(
    parameter int unsigned N_MASTER = 4,
    parameter int unsigned N_BANK   = 4
)
(
    input logic                            clk,
    input logic                            rst_n_i,
    input logic [N_MASTER-1:0]             req_i,
    input logic [N_MASTER-1:0]             gnt_o,
    input logic [N_BANK-1:0]               bank_req_o,
    input logic [N_BANK-1:0][N_MASTER-1:0] bank_id_o,
    input logic [N_BANK-1:0][N_MASTER-1:0] arb_gnt      // Internal grant matrix
);

    for (genvar b = 0; b < N_BANK; b++)
    begin : g_bank_chk
        // Exactly one master named at a requesting bank
        a_id_onehot : assert property (@(posedge clk) disable iff (!rst_n_i)
            bank_req_o[b] |-> $onehot(bank_id_o[b]))
            else $error("bank %0d ID not one-hot", b);
    end

    for (genvar m = 0; m < N_MASTER; m++)
    begin : g_mst_chk
        logic [N_BANK-1:0] col;    // Grants seen by master m

        for (genvar b = 0; b < N_BANK; b++)
        begin : g_col
            assign col[b] = arb_gnt[b][m];
        end

        a_one_gnt : assert property (@(posedge clk) disable iff (!rst_n_i)
            $onehot0(col))
            else $error("master %0d granted by several banks", m);

        a_gnt_req : assert property (@(posedge clk) disable iff (!rst_n_i)
            gnt_o[m] |-> req_i[m])
            else $error("master %0d granted without request", m);
    end

endmodule

bind tcdm_xbar tcdm_xbar_props #(
    .N_MASTER ( N_MASTER ),
    .N_BANK   ( N_BANK   )
) tcdm_xbar_props_i (
    .clk        ( clk        ),
    .rst_n_i    ( rst_n_i    ),
    .req_i      ( req_i      ),
    .gnt_o      ( gnt_o      ),
    .bank_req_o ( bank_req_o ),
    .bank_id_o  ( bank_id_o  ),
    .arb_gnt    ( arb_gnt    )
);

// File: tests/tb_clock_gen.sv
/* Testbench clock and reset
   Free running clock, reset held low for a fixed number of cycles */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter real         PERIOD_NS  = 4.0,
    parameter int unsigned RST_CYCLES = 10
)
(
    output logic clk_o,
    output logic rst_n_o
);

    initial
    begin
        clk_o = 1'b0;
        forever #(PERIOD_NS/2.0) clk_o = ~clk_o;
    end

    // Sync reset, released just after an edge
    initial
    begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        #1 rst_n_o = 1'b1;
    end

endmodule

// File: source/tcdm_xbar.sv
/* TCDM crossbar top
   Master ports and per-bank arbiters, joined by request/grant transposes */
`timescale 1ns/1ps

module tcdm_xbar
    import xbar_cfg_pkg::*, xbar_types_pkg::*;
#(
    parameter int unsigned N_MASTER = 4,
    parameter int unsigned N_BANK   = 4    // Power of two
)
(
    input  logic                               clk,
    input  logic                               rst_n_i,

    // Master side
    input  logic [N_MASTER-1:0]                req_i,
    input  mst_req_t [N_MASTER-1:0]            mst_req_i,
    output logic [N_MASTER-1:0]                gnt_o,
    output logic [N_MASTER-1:0]                r_valid_o,
    output data_t [N_MASTER-1:0]               r_rdata_o,

    // Bank side, word interleaved
    output logic [N_BANK-1:0]                  bank_req_o,
    output bank_req_t [N_BANK-1:0]             bank_payload_o,
    output logic [N_BANK-1:0][N_MASTER-1:0]    bank_id_o,
    input  logic [N_BANK-1:0]                  bank_gnt_i,
    input  logic [N_BANK-1:0]                  bank_r_valid_i,
    input  data_t [N_BANK-1:0]                 bank_r_rdata_i,
    input  logic [N_BANK-1:0][N_MASTER-1:0]    bank_r_id_i       // Echoed request ID
);

    // Master view, indexed [master][bank]
    logic [N_MASTER-1:0][N_BANK-1:0] mst_bank_req;
    logic [N_MASTER-1:0][N_BANK-1:0] mst_bank_gnt;
    logic [N_MASTER-1:0][N_BANK-1:0] mst_rsp_valid;
    bank_req_t [N_MASTER-1:0]        mst_payload;   // Decoded payload per master

    // Bank view, indexed [bank][master]
    logic [N_BANK-1:0][N_MASTER-1:0] arb_req;
    logic [N_BANK-1:0][N_MASTER-1:0] arb_gnt;

    ////////////////////////////////
    // Matrix transposes
    ////////////////////////////////
    for (genvar m = 0; m < N_MASTER; m++)
    begin : g_xpose_m
        for (genvar b = 0; b < N_BANK; b++)
        begin : g_xpose_b
            assign arb_req[b][m]       = mst_bank_req[m][b];
            assign mst_bank_gnt[m][b]  = arb_gnt[b][m];
            // ID bit m of bank b marks a response for master m
            assign mst_rsp_valid[m][b] = bank_r_valid_i[b] & bank_r_id_i[b][m];
        end
    end

    ////////////////////////////////
    // Master ports
    ////////////////////////////////
    for (genvar m = 0; m < N_MASTER; m++)
    begin : g_mst
        master_port #(
            .N_BANK         ( N_BANK             )
        ) master_port_i (
            .req_i          ( req_i[m]           ),
            .mst_req_i      ( mst_req_i[m]       ),
            .gnt_o          ( gnt_o[m]           ),
            .r_valid_o      ( r_valid_o[m]       ),
            .r_rdata_o      ( r_rdata_o[m]       ),
            .bank_req_o     ( mst_bank_req[m]    ),
            .bank_payload_o ( mst_payload[m]     ),
            .bank_gnt_i     ( mst_bank_gnt[m]    ),
            .rsp_valid_i    ( mst_rsp_valid[m]   ),
            .rsp_rdata_i    ( bank_r_rdata_i     )   // Every bank, filtered by valid
        );
    end

    // One arbiter per bank, each sees all payloads
    for (genvar b = 0; b < N_BANK; b++)
    begin : g_bank
        bank_arbiter #(
            .N_MASTER       ( N_MASTER           )
        ) bank_arbiter_i (
            .clk            ( clk                ),
            .rst_n_i        ( rst_n_i            ),
            .req_i          ( arb_req[b]         ),
            .payload_i      ( mst_payload        ),
            .gnt_o          ( arb_gnt[b]         ),
            .bank_req_o     ( bank_req_o[b]      ),
            .bank_payload_o ( bank_payload_o[b]  ),
            .bank_id_o      ( bank_id_o[b]       ),
            .bank_gnt_i     ( bank_gnt_i[b]      )
        );
    end

endmodule

// File: source/bank_arbiter.sv
/* Round-robin arbiter in front of one memory bank
   Forwards the winning request with its one-hot master ID */
`timescale 1ns/1ps

module bank_arbiter
    import xbar_types_pkg::*;
#(
    parameter int unsigned N_MASTER = 4
)
(
    input  logic                       clk,
    input  logic                       rst_n_i,        // Sync, active low

    // From the master ports
    input  logic [N_MASTER-1:0]        req_i,
    input  bank_req_t [N_MASTER-1:0]   payload_i,
    output logic [N_MASTER-1:0]        gnt_o,

    // Bank side
    output logic                       bank_req_o,
    output bank_req_t                  bank_payload_o,
    output logic [N_MASTER-1:0]        bank_id_o,      // One-hot winner
    input  logic                       bank_gnt_i
);

    localparam int unsigned PTR_W = (N_MASTER > 1) ? $clog2(N_MASTER) : 1;

    logic [PTR_W-1:0] ptr_q;       // Highest priority master this cycle
    logic [PTR_W-1:0] win_idx;     // Selected master
    logic             win_found;

    ////////////////////////////////
    // Winner search
    ////////////////////////////////
    always_comb
    begin
        int unsigned cand;

        win_found = 1'b0;
        win_idx   = ptr_q;
        cand      = 0;
        // Scan from the pointer upward, wrap to master 0
        for (int unsigned k = 0; k < N_MASTER; k++)
        begin
            cand = int'(ptr_q) + k;
            if (cand >= N_MASTER)
            begin
                cand = cand - N_MASTER;
            end
            if (!win_found && req_i[cand])
            begin
                win_found = 1'b1;
                win_idx   = PTR_W'(cand);
            end
        end
    end

    // Request seen by the bank, stays up under back-pressure
    assign bank_req_o     = win_found;
    assign bank_payload_o = payload_i[win_idx];

    always_comb
    begin
        bank_id_o = '0;
        if (win_found)
        begin
            bank_id_o[win_idx] = 1'b1;
        end
    end

    assign gnt_o = bank_id_o & {N_MASTER{bank_gnt_i}};   // Winner only, and only if accepted

    ////////////////////////////////
    // Priority pointer
    ////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (!rst_n_i)
        begin
            ptr_q <= '0;                                 // Master 0 first after reset
        end
        else if (win_found && bank_gnt_i)
        begin
            // Winner drops to lowest priority
            if (win_idx == PTR_W'(N_MASTER-1))
                ptr_q <= '0;
            else
                ptr_q <= win_idx + 1'b1;
        end
    end

endmodule

// File: source/master_port.sv
/* Master port of the TCDM crossbar
   Decodes the target bank, merges bank grants and picks the response */
`timescale 1ns/1ps

module master_port
    import xbar_cfg_pkg::*, xbar_types_pkg::*;
#(
    parameter int unsigned N_BANK = 4      // Power of two
)
(
    // Master side
    input  logic                   req_i,          // Held until granted
    input  mst_req_t               mst_req_i,
    output logic                   gnt_o,
    output logic                   r_valid_o,
    output data_t                  r_rdata_o,

    // Toward the bank arbiters
    output logic [N_BANK-1:0]      bank_req_o,     // One-hot on the decoded bank
    output bank_req_t              bank_payload_o,
    input  logic [N_BANK-1:0]      bank_gnt_i,

    // Response path, already filtered by ID
    input  logic [N_BANK-1:0]      rsp_valid_i,
    input  data_t [N_BANK-1:0]     rsp_rdata_i
);

    localparam int unsigned SEL_BITS = $clog2(N_BANK);
    localparam int unsigned IDX_W    = (SEL_BITS > 0) ? SEL_BITS : 1;

    logic [IDX_W-1:0] bank_idx;    // Decoded target bank

    ////////////////////////////////
    // Address decode
    ////////////////////////////////
    if (SEL_BITS == 0)
    begin : g_one_bank
        assign bank_idx = '0;      // Single bank, nothing to route
    end
    else
    begin : g_many_banks
        // Word interleaving, bank bits sit right above the byte offset
        assign bank_idx = mst_req_i.addr[BYTE_OFFSET +: SEL_BITS];
    end

    // Local word address lives above the bank bits
    assign bank_payload_o.addr  = mst_req_i.addr[BYTE_OFFSET + SEL_BITS +: BANK_ADDR_WIDTH];
    assign bank_payload_o.wen   = mst_req_i.wen;
    assign bank_payload_o.wdata = mst_req_i.wdata;
    assign bank_payload_o.be    = mst_req_i.be;

    always_comb
    begin
        for (int unsigned b = 0; b < N_BANK; b++)
        begin
            bank_req_o[b] = req_i && (bank_idx == IDX_W'(b));   // Only the decoded bank
        end
    end

    // Only the addressed arbiter can grant us
    assign gnt_o = |bank_gnt_i;

    ////////////////////////////////
    // Response select
    ////////////////////////////////
    assign r_valid_o = |rsp_valid_i;

    always_comb
    begin
        r_rdata_o = '0;
        // At most one bank answers a given master per cycle
        for (int unsigned b = 0; b < N_BANK; b++)
        begin
            if (rsp_valid_i[b])
            begin
                r_rdata_o = rsp_rdata_i[b];
            end
        end
    end

endmodule

// File: source/xbar_types_pkg.sv
/* TCDM crossbar payload types
   Request bundles seen by the masters and by the memory banks */
package xbar_types_pkg;

    import xbar_cfg_pkg::*;

    // Master request, full byte address
    // The one-hot ID travels beside it so N_MASTER stays free
    typedef struct packed
    {
        addr_t addr;    // Byte address, bank bits included
        logic  wen;     // 1 load, 0 store
        data_t wdata;   // Store data
        be_t   be;      // Byte enables
    } mst_req_t;

    ////////////////////////////////
    // Bank request, after decode
    ////////////////////////////////
    typedef struct packed
    {
        bank_addr_t addr;   // Word address local to the bank
        logic       wen;    // 1 load, 0 store
        data_t      wdata;  // Store data
        be_t        be;     // Byte enables
    } bank_req_t;

    // Bank select bits and byte offset are stripped here,
    // the bank index is implied by which bank port is driven

endpackage

// File: source/xbar_cfg_pkg.sv
/* TCDM crossbar configuration
   Word and address widths, plus the constants behind bank interleaving */
package xbar_cfg_pkg;

    ////////////////////////////////
    // Master side widths
    ////////////////////////////////
    localparam int unsigned ADDR_WIDTH = 32;            // Byte address from the masters
    localparam int unsigned DATA_WIDTH = 32;            // One memory word
    localparam int unsigned BE_WIDTH   = DATA_WIDTH/8;  // One enable per byte lane

    // Low address bits that pick a byte inside a word
    localparam int unsigned BYTE_OFFSET = 2;

    ////////////////////////////////
    // Bank side widths
    ////////////////////////////////
    localparam int unsigned BANK_ADDR_WIDTH = 12;       // Word address inside one bank

    typedef logic [ADDR_WIDTH-1:0]      addr_t;
    typedef logic [DATA_WIDTH-1:0]      data_t;
    typedef logic [BE_WIDTH-1:0]        be_t;
    typedef logic [BANK_ADDR_WIDTH-1:0] bank_addr_t;

endpackage
